// ==== source/heapPackage.sv ====
// Shared sizes, action and error enums and the stage records of the heap.
// Every heap stage imports this package by wildcard.
`default_nettype none

package heapPackage;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int addressBits = 2;                        // Width of an array number
  localparam int indexBits   = 2;                        // Width of an element index
  localparam int dataBits    = 12;                       // Width of an element
  localparam int arrayCount  = 1 << addressBits;         // Arrays in the heap
  localparam int arrayLength = 1 << indexBits;           // Elements per array
  localparam int sizeBits    = indexBits + 1;            // Holds 0 to arrayLength
  localparam int countBits   = addressBits + 1;          // Holds 0 to arrayCount

  typedef enum logic [3:0] {
    clearAll,                                            // Forget every array
    alloc,                                               // New array, freed ones first
    free,                                                // Return an array for reuse
    write,                                               // Store, may grow the size
    read,                                                // Load within the size
    size,                                                // Current element count
    push,                                                // Append at the end
    pop,                                                 // Remove from the end
    add,                                                 // Returns new value
    addAfter,                                            // Returns previous value
    subtract,                                            // Returns new value
    subAfter,                                            // Returns previous value
    orBits,
    xorBits,
    andBits
  } heapAction;

  typedef enum logic [2:0] {
    none,
    notAllocated,                                        // Never handed out since clear
    alreadyFreed,                                        // Double free or use after free
    outOfBounds,                                         // Index not below the size
    arrayFull,
    arrayEmpty,
    outOfMemory                                          // No freed or unused array left
  } heapError;

  // ----------------------------------------
  // Stage records
  // ----------------------------------------
  typedef struct packed {
    logic                   valid;
    heapAction              action;
    logic [addressBits-1:0] array;
    logic [indexBits-1:0]   index;
    logic [dataBits-1:0]    data;
  } heapRequest;

  typedef struct packed {
    logic                   valid;
    heapAction              action;
    logic [addressBits-1:0] array;
    logic [indexBits-1:0]   index;                       // Resolved for push and pop
    logic [dataBits-1:0]    data;
    heapError               error;
    logic [dataBits-1:0]    result;                      // Array number or size
  } checkedRequest;

  typedef struct packed {
    checkedRequest          request;
    logic [dataBits-1:0]    current;                     // Element value before update
  } readRequest;

  typedef struct packed {
    logic                   enable;
    logic [addressBits-1:0] array;
    logic [indexBits-1:0]   index;
    logic [dataBits-1:0]    data;
  } elementWrite;

  typedef struct packed {
    logic                   valid;
    logic [dataBits-1:0]    data;
    heapError               error;
  } heapResponse;

endpackage

`default_nettype wire

// ==== source/heapRequestCheck.sv ====
// Stage 1 of the heap pipeline. Validates each request against the
// allocation and size tables, applies allocation and size effects in
// request order and resolves push and pop to an element index.
`timescale 1ns/10ps
`default_nettype none

module heapRequestCheck import heapPackage::*; (
  input  wire logic    clock,
  input  wire logic    resetN,
  input  heapRequest   request,
  output checkedRequest checked
);

  logic [arrayCount-1:0]  allocated;                      // Live arrays
  logic [sizeBits-1:0]    sizes [arrayCount];             // Elements in use per array
  logic [addressBits-1:0] freedStack [arrayCount];        // Arrays waiting for reuse
  logic [countBits-1:0]   freedTop;                       // Entries on freedStack
  logic [countBits-1:0]   nextUnused;                     // Arrays ever handed out

  logic [sizeBits-1:0]    arraySize;
  logic                   neverUsed;
  logic                   fromFreed;
  logic [addressBits-1:0] topBelow;
  logic [addressBits-1:0] grantArray;                     // Array an alloc would return
  heapError               errorKind;
  logic [indexBits-1:0]   resolvedIndex;
  logic [dataBits-1:0]    resultValue;
  logic                   apply;                          // Request takes effect

  assign arraySize  = sizes[request.array];
  assign neverUsed  = {1'b0, request.array} >= nextUnused;
  assign fromFreed  = freedTop != '0;
  assign topBelow   = freedTop[addressBits-1:0] - 1'b1;
  assign grantArray = fromFreed ? freedStack[topBelow] : nextUnused[addressBits-1:0];
  assign apply      = request.valid && errorKind == none;

  // ----------------------------------------
  // Error classification
  // ----------------------------------------
  always_comb begin
    errorKind = none;
    case (request.action)
      clearAll: errorKind = none;                         // Always allowed
      alloc: begin
        if (!fromFreed && nextUnused == countBits'(arrayCount)) errorKind = outOfMemory;
      end
      default: begin
        if (neverUsed) errorKind = notAllocated;
        else if (!allocated[request.array]) errorKind = alreadyFreed;
        else begin
          case (request.action)
            read, add, addAfter, subtract, subAfter, orBits, xorBits, andBits: begin
              if ({1'b0, request.index} >= arraySize) errorKind = outOfBounds;
            end
            push: if (arraySize == sizeBits'(arrayLength)) errorKind = arrayFull;
            pop:  if (arraySize == '0) errorKind = arrayEmpty;
            default: ;                                    // Write, size, free
          endcase
        end
      end
    endcase
  end

  // Index and result value carried downstream
  always_comb begin
    resolvedIndex = request.index;
    resultValue   = '0;
    case (request.action)
      push:    resolvedIndex = arraySize[indexBits-1:0];         // Old size
      pop:     resolvedIndex = arraySize[indexBits-1:0] - 1'b1;  // New size
      alloc:   resultValue   = dataBits'(grantArray);
      size:    resultValue   = dataBits'(arraySize);
      default: ;
    endcase
  end

  // ----------------------------------------
  // Allocation control and output register
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated  <= '0;
      freedTop   <= '0;
      nextUnused <= '0;
      checked    <= '0;
    end else begin
      checked.valid  <= request.valid;
      checked.action <= request.action;
      checked.array  <= request.array;
      checked.index  <= resolvedIndex;
      checked.data   <= request.data;
      checked.error  <= errorKind;
      checked.result <= resultValue;
      if (apply) begin
        case (request.action)
          clearAll: begin
            allocated  <= '0;
            freedTop   <= '0;
            nextUnused <= '0;
          end
          alloc: begin
            allocated[grantArray] <= 1'b1;
            if (fromFreed) freedTop <= freedTop - 1'b1;     // Reuse first
            else nextUnused <= nextUnused + 1'b1;
          end
          free: begin
            allocated[request.array] <= 1'b0;
            freedTop <= freedTop + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Size table and freed stack contents
  always_ff @(posedge clock) begin
    if (apply) begin
      case (request.action)
        alloc: sizes[grantArray] <= '0;                   // Fresh array is empty
        free:  freedStack[freedTop[addressBits-1:0]] <= request.array;
        write: begin
          if ({1'b0, request.index} >= arraySize) begin
            sizes[request.array] <= {1'b0, request.index} + 1'b1;
          end
        end
        push:    sizes[request.array] <= arraySize + 1'b1;
        pop:     sizes[request.array] <= arraySize - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/heapElementRead.sv ====
// Stage 2 of the heap pipeline. Owns the element storage, reads the element
// addressed by stage 1 and bypasses the stage 3 writeback of the same cycle.
`timescale 1ns/10ps
`default_nettype none

module heapElementRead import heapPackage::*; (
  input  wire logic     clock,
  input  wire logic     resetN,
  input  checkedRequest checked,
  input  elementWrite   writeBack,
  output readRequest    fetched
);

  logic [dataBits-1:0] elements [arrayCount][arrayLength];   // All arrays, fixed blocks

  logic [dataBits-1:0] stored;                                // Value in storage
  logic                sameElement;                           // Writeback hits our element
  logic [dataBits-1:0] currentValue;

  // ----------------------------------------
  // Read with bypass
  // ----------------------------------------
  assign stored = elements[checked.array][checked.index];

  assign sameElement = writeBack.enable &&
                       writeBack.array == checked.array &&
                       writeBack.index == checked.index;

  // Previous request's result not yet in storage
  assign currentValue = sameElement ? writeBack.data : stored;

  // Storage write lands at the same edge that captures the bypassed value
  always_ff @(posedge clock) begin
    if (writeBack.enable) begin
      elements[writeBack.array][writeBack.index] <= writeBack.data;
    end
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      fetched <= '0;
    end else begin
      fetched.request <= checked;
      fetched.current <= currentValue;
    end
  end

endmodule

`default_nettype wire

// ==== source/heapElementUpdate.sv ====
// Stage 3 of the heap pipeline. Computes each action's new element value,
// drives the writeback to stage 2 straight from its input register and
// registers the response.
`timescale 1ns/10ps
`default_nettype none

module heapElementUpdate import heapPackage::*; (
  input  wire logic   clock,
  input  wire logic   resetN,
  input  readRequest  fetched,
  output elementWrite writeBack,
  output heapResponse response
);

  logic [dataBits-1:0] current;
  logic [dataBits-1:0] operand;
  logic [dataBits-1:0] newValue;                         // Element after the action
  logic                updates;                          // Action stores an element
  logic                clean;                            // Valid and error free
  logic [dataBits-1:0] responseData;

  assign current = fetched.current;
  assign operand = fetched.request.data;
  assign clean   = fetched.request.valid && fetched.request.error == none;

  // ----------------------------------------
  // Element arithmetic
  // ----------------------------------------
  always_comb begin
    newValue = current;
    updates  = 1'b1;
    case (fetched.request.action)
      write, push:        newValue = operand;
      add, addAfter:      newValue = current + operand;  // Wraps at dataBits
      subtract, subAfter: newValue = current - operand;
      orBits:             newValue = current | operand;
      xorBits:            newValue = current ^ operand;
      andBits:            newValue = current & operand;
      default:            updates  = 1'b0;
    endcase
  end

  // Combinational so stage 2 can bypass it in the same cycle
  assign writeBack.enable = clean && updates;
  assign writeBack.array  = fetched.request.array;
  assign writeBack.index  = fetched.request.index;
  assign writeBack.data   = newValue;

  always_comb begin
    case (fetched.request.action)
      alloc, size:                             responseData = fetched.request.result;
      write, push:                             responseData = newValue;
      read, pop:                               responseData = current;
      add, subtract, orBits, xorBits, andBits: responseData = newValue;
      addAfter, subAfter:                      responseData = current;   // Previous value
      default:                                 responseData = '0;        // Free, clearAll
    endcase
  end

  // ----------------------------------------
  // Response register
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      response <= '0;
    end else begin
      response.valid <= fetched.request.valid;
      response.error <= fetched.request.error;
      response.data  <= clean ? responseData : '0;         // Errors return zero
    end
  end

endmodule

`default_nettype wire

// ==== source/heapMemory.sv ====
// Top level of the pipelined heap. One request per cycle goes in, and its
// response comes out three clocks later with no back-pressure.
`timescale 1ns/10ps
`default_nettype none

module heapMemory import heapPackage::*; (
  input  wire logic  clock,
  input  wire logic  resetN,
  input  heapRequest request,
  output heapResponse response
);

  checkedRequest checked;                                // Stage 1 to stage 2
  readRequest    fetched;                                // Stage 2 to stage 3
  elementWrite   writeBack;                              // Stage 3 back to stage 2

  heapRequestCheck checkStage (
    .clock   (clock),
    .resetN  (resetN),
    .request (request),
    .checked (checked)
  );

  heapElementRead readStage (
    .clock     (clock),
    .resetN    (resetN),
    .checked   (checked),
    .writeBack (writeBack),
    .fetched   (fetched)
  );

  heapElementUpdate updateStage (
    .clock     (clock),
    .resetN    (resetN),
    .fetched   (fetched),
    .writeBack (writeBack),
    .response  (response)
  );

endmodule

`default_nettype wire

// ==== bench/heapMemory_checker.sv ====
// Concurrent checks on the heap's top-level ports. Bound into every
// heapMemory instance; the testbench reads failureCount at the end.
`timescale 1ns/10ps
`default_nettype none

module heapMemory_checker import heapPackage::*; (
  input wire logic   clock,
  input wire logic   resetN,
  input heapRequest  request,
  input heapResponse response
);

  int failureCount = 0;                                  // Assertion failures so far

  // ----------------------------------------
  // Reset and latency
  // ----------------------------------------
  resetQuiet: assert property (@(posedge clock) !resetN |-> !response.valid)
    else begin
      $error("response valid while reset is low");
      failureCount++;
    end

  // One response per request, three clocks later
  fixedLatency: assert property (@(posedge clock) disable iff (!resetN)
      response.valid == $past(request.valid, 3))
    else begin
      $error("response valid does not follow request valid by three cycles");
      failureCount++;
    end

  errorDataZero: assert property (@(posedge clock) disable iff (!resetN)
      response.valid && response.error != none |-> response.data == '0)
    else begin
      $error("erroring response carries nonzero data");
      failureCount++;
    end

endmodule

bind heapMemory heapMemory_checker responseCheck (
  .clock    (clock),
  .resetN   (resetN),
  .request  (request),
  .response (response)
);

`default_nettype wire

// ==== bench/heapMemoryBench.sv ====
// Testbench for the pipelined heap. Applies a table of requests, one per
// falling clock edge, and compares each response three clocks later.
// Ends with a count line and the overall verdict.
`timescale 1ns/10ps
`default_nettype none

module heapMemoryBench import heapPackage::*; ();

  localparam int clockPeriod = 4;                        // ns
  localparam int burstLength = 16;                       // Back-to-back adds
  localparam heapResponse idleResponse = '0;

  typedef struct packed {
    heapRequest  request;
    heapResponse expected;
  } tableEntry;

  logic        clock;
  logic        resetN;
  logic        tableReady;
  heapRequest  request;
  heapResponse response;

  tableEntry   steps [$];                                // Stimulus table
  heapResponse pending [$];                              // One entry per driven cycle
  int          checkCount;
  int          valueErrors;
  int          otherErrors;

  heapMemory uut (
    .clock    (clock),
    .resetN   (resetN),
    .request  (request),
    .response (response)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    state = state ^ (state << 13);
    state = state ^ (state >> 17);
    state = state ^ (state << 5);
    return state;
  endfunction

  task automatic addStep(input heapAction action, input int array, input int index,
                         input int data, input int expData, input heapError expError);
    tableEntry entry;
    entry.request.valid  = 1'b1;
    entry.request.action = action;
    entry.request.array  = addressBits'(array);
    entry.request.index  = indexBits'(index);
    entry.request.data   = dataBits'(data);
    entry.expected.valid = 1'b1;
    entry.expected.data  = dataBits'(expData);
    entry.expected.error = expError;
    steps.push_back(entry);
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic buildTable();
    logic [31:0]         state;
    logic [dataBits-1:0] addend;
    logic [dataBits-1:0] sum;
    addStep(clearAll, 0, 0, 0, 0, none);
    addStep(read,     2, 0, 0, 0, notAllocated);         // Nothing handed out yet
    addStep(push,     3, 0, 5, 0, notAllocated);
    addStep(size,     1, 0, 0, 0, notAllocated);
    addStep(free,     0, 0, 0, 0, notAllocated);
    addStep(alloc,    0, 0, 0, 0, none);
    addStep(alloc,    0, 0, 0, 1, none);
    addStep(free,     0, 0, 0, 0, none);
    addStep(alloc,    0, 0, 0, 0, none);                 // Freed array reused
    addStep(free,     1, 0, 0, 0, none);
    addStep(free,     1, 0, 0, 0, alreadyFreed);         // Double free
    addStep(alloc,    0, 0, 0, 1, none);
    addStep(alloc,    0, 0, 0, 2, none);
    addStep(alloc,    0, 0, 0, 3, none);
    addStep(alloc,    0, 0, 0, 0, outOfMemory);          // Fifth live array
    addStep(push,     1, 0, 1, 1, none);
    addStep(push,     1, 0, 2, 2, none);
    addStep(size,     1, 0, 0, 2, none);
    addStep(read,     1, 0, 0, 1, none);
    addStep(read,     1, 1, 0, 2, none);
    addStep(read,     1, 2, 0, 0, outOfBounds);
    addStep(pop,      1, 0, 0, 2, none);                 // Last pushed first
    addStep(size,     1, 0, 0, 1, none);
    addStep(pop,      1, 0, 0, 1, none);
    addStep(pop,      1, 0, 0, 0, arrayEmpty);
    addStep(push,     1, 0, 10, 10, none);
    addStep(push,     1, 0, 11, 11, none);
    addStep(push,     1, 0, 12, 12, none);
    addStep(push,     1, 0, 13, 13, none);
    addStep(push,     1, 0, 14, 0, arrayFull);
    addStep(size,     1, 0, 0, 4, none);
    addStep(read,     1, 3, 0, 13, none);
    addStep(write,    2, 0, 100, 100, none);             // Grows size to 1
    addStep(add,      2, 0, 50, 150, none);
    addStep(addAfter, 2, 0, 25, 150, none);              // Element now 175
    addStep(subtract, 2, 0, 200, 4071, none);            // 175 - 200 wraps
    addStep(subAfter, 2, 0, 71, 4071, none);             // Element now 4000
    addStep(orBits,   2, 0, 'h0FF, 'hFFF, none);
    addStep(xorBits,  2, 0, 'h0F0, 'hF0F, none);
    addStep(andBits,  2, 0, 'h3C3, 'h303, none);
    addStep(add,      2, 0, 'hD00, 'h003, none);         // Carry out dropped
    addStep(read,     2, 0, 0, 'h003, none);
    // Running sum burst on array 3, index 2
    state = 32'hb422;
    sum   = '0;
    addStep(write, 3, 2, 0, 0, none);
    for (int i = 0; i < burstLength; i++) begin
      state  = nextRandom(state);
      addend = state[dataBits-1:0];
      sum    = sum + addend;                             // Modulo 2**dataBits
      addStep(add, 3, 2, addend, sum, none);
    end
    addStep(read, 3, 2, 0, sum, none);
  endtask

  // ----------------------------------------
  // Response compare on every falling edge
  // ----------------------------------------
  task automatic checkResponse();
    heapResponse expected;
    heapError    wantError;
    heapError    gotError;
    if (pending.size() == 3) begin                       // Entry from three clocks back
      expected  = pending.pop_front();
      wantError = expected.error;
      gotError  = response.error;
      if (!expected.valid) begin
        assert (!response.valid) else begin
          $display("Response appeared at %0t with no request expected", $time);
          otherErrors++;
        end
      end else begin
        checkCount++;
        assert (response.valid) else begin
          $display("CHECK FAILED at %0t: response.valid expected 1 got 0", $time);
          valueErrors++;
        end
        assert (response.data == expected.data) else begin
          $display("CHECK FAILED at %0t: response.data expected %0d got %0d",
                   $time, expected.data, response.data);
          valueErrors++;
        end
        assert (gotError == wantError) else begin
          $display("CHECK FAILED at %0t: response.error expected %s got %s",
                   $time, wantError.name(), gotError.name());
          valueErrors++;
        end
      end
    end
  endtask

  initial begin
    request     = '0;
    resetN      = 1'b1;
    tableReady  = 1'b0;
    checkCount  = 0;
    valueErrors = 0;
    otherErrors = 0;
    buildTable();
    tableReady = 1'b1;
    #1 resetN = 1'b0;                                    // Clean falling edge on reset
    repeat (3) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    foreach (steps[i]) begin
      @(negedge clock);
      checkResponse();
      request = steps[i].request;
      pending.push_back(steps[i].expected);
    end
    repeat (6) begin                                     // Drain and watch for stray responses
      @(negedge clock);
      checkResponse();
      request = '0;
      pending.push_back(idleResponse);
    end
    $display("Checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
             checkCount, valueErrors, otherErrors, uut.responseCheck.failureCount);
    if (valueErrors + otherErrors + uut.responseCheck.failureCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (tableReady);
    #((steps.size() + 20) * clockPeriod);
    $display("Watchdog expired at %0t before the table was finished", $time);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/heapPackage.sv
source/heapRequestCheck.sv
source/heapElementRead.sv
source/heapElementUpdate.sv
source/heapMemory.sv
bench/heapMemory_checker.sv
bench/heapMemoryBench.sv
